/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 16;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_BEAT = 4;

    // read burst encodings, four beats of 16 bytes
    localparam logic [7:0] BURST_LEN  = 8'd3;
    localparam logic [2:0] BURST_SIZE = 3'd4;
    localparam logic [1:0] BURST_INCR = 2'b01;

    localparam logic [4:0] EXC_FETCH_ACCESS = 5'd1;

    typedef logic [31:0]         addr_t;
    typedef logic [31:0]         word_t;
    typedef logic [127:0]        beat_t;
    typedef logic [18:0]         tag_t;
    typedef logic [6:0]          set_idx_t;
    typedef logic [3:0]          word_off_t;
    typedef logic [1:0]          way_idx_t;
    typedef logic [NUM_WAYS-1:0] way_vec_t;
    typedef logic [1:0]          beat_idx_t;
    typedef logic [10:0]         data_idx_t;
    typedef logic [2:0]          plru_t;

    typedef struct packed {
        tag_t       tag;
        set_idx_t   set_idx;
        word_off_t  word_off;
        logic [1:0] byte_off;
    } fetch_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } ar_req_t;

    // one refill beat into the data array
    typedef struct packed {
        logic      we;
        way_idx_t  way;
        set_idx_t  set_idx;
        beat_idx_t beat;
        beat_t     data;
    } fill_t;

    typedef enum logic [1:0] {
        S_RUN,
        S_MISS_REQUEST,
        S_REFILL,
        S_REFILL_DONE
    } icache_state_e;

endpackage

`default_nettype wire

/* icache/icache_plru.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_plru
    import icache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     resetn,

    input  wire logic     touch_i,
    input  wire way_idx_t touch_way_i,

    output way_idx_t      victim_o
);
    plru_t plru_q;

    // bit 2 picks the pair, bit 1 within 0-1, bit 0 within 2-3
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            plru_q <= '0;
        end else if (touch_i) begin
            case (touch_way_i)
                2'd0:    plru_q <= {2'b11, plru_q[0]};
                2'd1:    plru_q <= {2'b10, plru_q[0]};
                2'd2:    plru_q <= {1'b0, plru_q[1], 1'b1};
                default: plru_q <= {1'b0, plru_q[1], 1'b0};
            endcase
        end
    end

    assign victim_o = {plru_q[2], plru_q[2] ? plru_q[0] : plru_q[1]};

    a_touch_known: assert property (@(posedge clk) disable iff (!resetn)
        touch_i |-> !$isunknown(touch_way_i));

endmodule

`default_nettype wire

/* icache/icache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,

    input  wire logic       rd_en_i,
    input  wire set_idx_t   rd_set_i,
    input  wire tag_t       req_tag_i,

    input  wire logic       we_i,
    input  wire way_idx_t   wr_way_i,
    input  wire set_idx_t   wr_set_i,
    input  wire tag_entry_t wr_entry_i,

    output way_vec_t        hit_o,
    output logic            all_valid_o,
    output way_idx_t        first_invalid_o
);
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    tag_t                tag_mem [NUM_WAYS][NUM_SETS];
    way_vec_t            rd_valid_q;
    tag_t                rd_tag_q [NUM_WAYS];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            rd_valid_q <= '0;
        end else begin
            if (we_i) begin
                valid_q[wr_way_i][wr_set_i] <= wr_entry_i.valid;
            end
            if (rd_en_i) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    rd_valid_q[w] <= valid_q[w][rd_set_i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_way_i][wr_set_i] <= wr_entry_i.tag;
        end
        if (rd_en_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_q[w] <= tag_mem[w][rd_set_i];
            end
        end
    end

    // walk down so the lowest invalid way wins
    always_comb begin
        first_invalid_o = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            hit_o[w] = rd_valid_q[w] && (rd_tag_q[w] == req_tag_i);
            if (!rd_valid_q[w]) begin
                first_invalid_o = way_idx_t'(w);
            end
        end
    end

    assign all_valid_o = &rd_valid_q;

endmodule

`default_nettype wire

/* icache/icache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_data_array
    import icache_pkg::*;
(
    input  wire logic      clk,

    input  wire logic      rd_en_i,
    input  wire data_idx_t rd_idx_i,
    input  wire way_vec_t  hit_i,
    input  wire fill_t     fill_i,

    output word_t          rd_word_o
);
    word_t rd_q [NUM_WAYS];

    // one word-wide RAM per way, indexed by {set, word offset}
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        word_t mem [NUM_SETS*WORDS_PER_LINE];

        always_ff @(posedge clk) begin
            if (rd_en_i) begin
                rd_q[w] <= mem[rd_idx_i];
            end
            if (fill_i.we && (fill_i.way == way_idx_t'(w))) begin
                for (int k = 0; k < WORDS_PER_BEAT; k++) begin
                    mem[{fill_i.set_idx, fill_i.beat, 2'(k)}] <= fill_i.data[k*32 +: 32];
                end
            end
        end
    end

    // hit vector is one-hot, so an or of the gated words is enough
    always_comb begin
        rd_word_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_i[w]) begin
                rd_word_o |= rd_q[w];
            end
        end
    end

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,

    input  wire logic       req_i,
    input  wire addr_t      addr_i,
    output logic            mem_ready_o,
    input  wire logic       instr_ready_i,
    output word_t           instr_o,
    output logic            instr_valid_o,
    output logic            exc_valid_o,
    output logic [4:0]      exc_code_o,

    input  wire way_vec_t   hit_i,
    input  wire logic       all_valid_i,
    input  wire way_idx_t   first_invalid_i,
    input  wire way_idx_t   victim_i,
    input  wire word_t      rd_word_i,

    output logic            rd_en_o,
    output data_idx_t       rd_idx_o,
    output tag_t            req_tag_o,
    output fill_t           fill_o,
    output logic            tag_we_o,
    output tag_entry_t      tag_wr_o,
    output way_idx_t        tag_way_o,
    output set_idx_t        tag_set_o,
    output logic            touch_o,
    output way_idx_t        touch_way_o,

    input  wire logic       arready_i,
    output ar_req_t         ar_o,
    input  wire logic       rvalid_i,
    input  wire beat_t      rdata_i,
    input  wire logic [1:0] rresp_i,
    output logic            rready_o
);
    icache_state_e state_q;
    logic          req_q;
    logic          err_q;
    beat_idx_t     beat_q;
    fetch_addr_t   addr_q;
    fetch_addr_t   addr_in;
    way_idx_t      fill_way_q;
    word_t         word_q;
    way_idx_t      hit_way;
    logic          hit;
    logic          miss;
    logic          stall;
    logic          accept;
    logic          beat_take;

    assign addr_in   = fetch_addr_t'(addr_i);
    assign hit       = (state_q == S_RUN) && req_q && (|hit_i);
    assign miss      = (state_q == S_RUN) && req_q && !(|hit_i);
    assign stall     = instr_valid_o && !instr_ready_i;
    assign beat_take = (state_q == S_REFILL) && rvalid_i;

    // no new lookup while a word waits or a miss is pending
    assign mem_ready_o = (state_q == S_RUN) && !miss && !stall;
    assign accept      = req_i && mem_ready_o;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_i[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= S_RUN;
            req_q   <= 1'b0;
            err_q   <= 1'b0;
            beat_q  <= '0;
        end else begin
            case (state_q)
                S_RUN: begin
                    if (miss) begin
                        state_q <= S_MISS_REQUEST;
                    end else if (!stall) begin
                        req_q <= accept;
                    end
                end
                S_MISS_REQUEST: begin
                    if (arready_i) begin
                        state_q <= S_REFILL;
                        beat_q  <= '0;
                        err_q   <= 1'b0;
                    end
                end
                S_REFILL: begin
                    if (rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        err_q  <= err_q | (rresp_i != 2'b00);
                        if (beat_q == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                            state_q <= S_REFILL_DONE;
                        end
                    end
                end
                S_REFILL_DONE: begin
                    // drop the request so stale tags are not compared again
                    if (instr_ready_i) begin
                        state_q <= S_RUN;
                        req_q   <= 1'b0;
                    end
                end
                default: state_q <= S_RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_in;
        end
        if (miss) begin
            fill_way_q <= all_valid_i ? victim_i : first_invalid_i;
        end
        // requested word comes in on beat word_off[3:2]
        if (beat_take && (addr_q.word_off[3:2] == beat_q)) begin
            word_q <= rdata_i[addr_q.word_off[1:0]*32 +: 32];
        end
    end

    always_comb begin
        instr_valid_o = 1'b0;
        exc_valid_o   = 1'b0;
        instr_o       = rd_word_i;
        if (state_q == S_RUN) begin
            instr_valid_o = hit;
        end else if (state_q == S_REFILL_DONE) begin
            instr_valid_o = !err_q;
            exc_valid_o   = err_q;
            instr_o       = word_q;
        end
    end

    assign exc_code_o = exc_valid_o ? EXC_FETCH_ACCESS : 5'd0;

    assign rd_en_o   = accept;
    assign rd_idx_o  = {addr_in.set_idx, addr_in.word_off};
    assign req_tag_o = addr_q.tag;

    assign fill_o = '{we: beat_take, way: fill_way_q, set_idx: addr_q.set_idx,
                      beat: beat_q, data: rdata_i};

    // a failed refill leaves the way invalid
    assign tag_we_o  = (state_q == S_REFILL_DONE) && instr_ready_i;
    assign tag_wr_o  = '{valid: !err_q, tag: addr_q.tag};
    assign tag_way_o = fill_way_q;
    assign tag_set_o = addr_q.set_idx;

    assign touch_o     = instr_valid_o && instr_ready_i;
    assign touch_way_o = (state_q == S_RUN) ? hit_way : fill_way_q;

    assign ar_o = '{valid: state_q == S_MISS_REQUEST,
                    addr: {addr_q.tag, addr_q.set_idx, 6'h00},
                    len: BURST_LEN, size: BURST_SIZE, burst: BURST_INCR};

    assign rready_o = (state_q == S_REFILL);

    // fetch unit sees a word or an exception, never both
    a_resp_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(instr_valid_o && exc_valid_o));

    a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        ar_o.valid && !arready_i |=> ar_o.valid && $stable(ar_o.addr));

    // tag array must never hold one line in two ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (!resetn)
        (state_q == S_RUN) && req_q |-> $onehot0(hit_i));

endmodule

`default_nettype wire

/* icache/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,

    input  wire logic       instr_mem_req_i,
    input  wire addr_t      instr_mem_addr_i,
    output logic            instr_mem_ready_o,

    input  wire logic       instr_ready_i,
    output word_t           instr_o,
    output logic            instr_valid_o,

    input  wire logic       arready_i,
    output addr_t           araddr_o,
    output logic [7:0]      arlen_o,
    output logic [2:0]      arsize_o,
    output logic [1:0]      arburst_o,
    output logic            arvalid_o,

    input  wire logic       rvalid_i,
    input  wire beat_t      rdata_i,
    input  wire logic [1:0] rresp_i,
    output logic            rready_o,

    output logic            exc_valid_o,
    output logic [4:0]      exc_code_o
);
    way_vec_t   hit;
    logic       all_valid;
    way_idx_t   first_invalid;
    way_idx_t   victim;
    word_t      rd_word;
    logic       rd_en;
    data_idx_t  rd_idx;
    tag_t       req_tag;
    fill_t      fill;
    logic       tag_we;
    tag_entry_t tag_wr;
    way_idx_t   tag_way;
    set_idx_t   tag_set;
    logic       touch;
    way_idx_t   touch_way;
    ar_req_t    ar;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .resetn          (resetn),
        .req_i           (instr_mem_req_i),
        .addr_i          (instr_mem_addr_i),
        .mem_ready_o     (instr_mem_ready_o),
        .instr_ready_i   (instr_ready_i),
        .instr_o         (instr_o),
        .instr_valid_o   (instr_valid_o),
        .exc_valid_o     (exc_valid_o),
        .exc_code_o      (exc_code_o),
        .hit_i           (hit),
        .all_valid_i     (all_valid),
        .first_invalid_i (first_invalid),
        .victim_i        (victim),
        .rd_word_i       (rd_word),
        .rd_en_o         (rd_en),
        .rd_idx_o        (rd_idx),
        .req_tag_o       (req_tag),
        .fill_o          (fill),
        .tag_we_o        (tag_we),
        .tag_wr_o        (tag_wr),
        .tag_way_o       (tag_way),
        .tag_set_o       (tag_set),
        .touch_o         (touch),
        .touch_way_o     (touch_way),
        .arready_i       (arready_i),
        .ar_o            (ar),
        .rvalid_i        (rvalid_i),
        .rdata_i         (rdata_i),
        .rresp_i         (rresp_i),
        .rready_o        (rready_o)
    );

    // set index is the top of the data index
    icache_tag_array u_tags (
        .clk             (clk),
        .resetn          (resetn),
        .rd_en_i         (rd_en),
        .rd_set_i        (rd_idx[10:4]),
        .req_tag_i       (req_tag),
        .we_i            (tag_we),
        .wr_way_i        (tag_way),
        .wr_set_i        (tag_set),
        .wr_entry_i      (tag_wr),
        .hit_o           (hit),
        .all_valid_o     (all_valid),
        .first_invalid_o (first_invalid)
    );

    icache_data_array u_data (
        .clk       (clk),
        .rd_en_i   (rd_en),
        .rd_idx_i  (rd_idx),
        .hit_i     (hit),
        .fill_i    (fill),
        .rd_word_o (rd_word)
    );

    icache_plru u_plru (
        .clk         (clk),
        .resetn      (resetn),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .victim_o    (victim)
    );

    assign araddr_o  = ar.addr;
    assign arlen_o   = ar.len;
    assign arsize_o  = ar.size;
    assign arburst_o = ar.burst;
    assign arvalid_o = ar.valid;

endmodule

`default_nettype wire

/* test/tb_axi_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       ar_stall_i,
    input  wire logic       r_stall_i,
    input  wire logic       arvalid_i,
    input  wire addr_t      araddr_i,
    output logic            arready_o,
    output logic            rvalid_o,
    output beat_t           rdata_o,
    output logic [1:0]      rresp_o,
    input  wire logic       rready_i
);
    logic       busy;
    logic       err;
    addr_t      base;
    logic [1:0] beat;
    logic       last;

    assign last = rvalid_o && rready_i && (beat == 2'd3);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy      <= 1'b0;
            err       <= 1'b0;
            base      <= '0;
            beat      <= '0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end else if (!busy) begin
            rvalid_o <= 1'b0;
            if (arvalid_i && arready_o) begin
                busy      <= 1'b1;
                arready_o <= 1'b0;
                base      <= araddr_i;
                beat      <= '0;
                // bit 20 marks the faulting region
                err       <= araddr_i[20];
            end else begin
                arready_o <= arvalid_i && !ar_stall_i;
            end
        end else begin
            if (rvalid_o && rready_i) begin
                beat <= beat + 2'd1;
            end
            if (last) begin
                busy <= 1'b0;
            end
            rvalid_o <= !r_stall_i && !last;
        end
    end

    // word at byte address A reads as A xor 5eed0000
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdata_o[k*32 +: 32] = (base + {beat, 4'h0} + 32'(k * 4)) ^ 32'h5EED_0000;
        end
    end

    assign rresp_o = err ? 2'b10 : 2'b00;

endmodule

`default_nettype wire

/* test/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_FETCHES  = 20 + NUM_RANDOM;

    logic        clk;
    logic        resetn;
    logic        instr_mem_req_i;
    addr_t       instr_mem_addr_i;
    logic        instr_mem_ready_o;
    logic        instr_ready_i;
    word_t       instr_o;
    logic        instr_valid_o;
    logic        arready_i;
    addr_t       araddr_o;
    logic [7:0]  arlen_o;
    logic [2:0]  arsize_o;
    logic [1:0]  arburst_o;
    logic        arvalid_o;
    logic        rvalid_i;
    beat_t       rdata_i;
    logic [1:0]  rresp_i;
    logic        rready_o;
    logic        exc_valid_o;
    logic [4:0]  exc_code_o;
    logic        ar_stall;
    logic        r_stall;
    logic        accepted;
    logic        delivered;

    // reference model, one tree for the whole cache
    tag_t        model_tag [128][4];
    logic        model_valid [128][4];
    logic [2:0]  model_plru;

    logic [15:0] lfsr;
    int          stall_cycles;
    string       test_name;
    word_t       exp_word;
    addr_t       exp_line;
    logic        exp_hit;
    logic        exp_exc;
    logic [1:0]  exp_way;
    int          ar_count;
    int          data_errors;
    int          proto_errors;

    icache_top uut (
        .clk               (clk),
        .resetn            (resetn),
        .instr_mem_req_i   (instr_mem_req_i),
        .instr_mem_addr_i  (instr_mem_addr_i),
        .instr_mem_ready_o (instr_mem_ready_o),
        .instr_ready_i     (instr_ready_i),
        .instr_o           (instr_o),
        .instr_valid_o     (instr_valid_o),
        .arready_i         (arready_i),
        .araddr_o          (araddr_o),
        .arlen_o           (arlen_o),
        .arsize_o          (arsize_o),
        .arburst_o         (arburst_o),
        .arvalid_o         (arvalid_o),
        .rvalid_i          (rvalid_i),
        .rdata_i           (rdata_i),
        .rresp_i           (rresp_i),
        .rready_o          (rready_o),
        .exc_valid_o       (exc_valid_o),
        .exc_code_o        (exc_code_o)
    );

    tb_axi_mem u_mem (
        .clk        (clk),
        .resetn     (resetn),
        .ar_stall_i (ar_stall),
        .r_stall_i  (r_stall),
        .arvalid_i  (arvalid_o),
        .araddr_i   (araddr_o),
        .arready_o  (arready_i),
        .rvalid_o   (rvalid_i),
        .rdata_o    (rdata_i),
        .rresp_o    (rresp_i),
        .rready_i   (rready_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign accepted  = instr_mem_req_i && instr_mem_ready_o;
    assign delivered = (instr_valid_o || exc_valid_o) && instr_ready_i;

    // bursts seen since the last accepted fetch
    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ar_count <= 0;
        end else if (accepted) begin
            ar_count <= 0;
        end else if (arvalid_o && arready_i) begin
            ar_count <= ar_count + 1;
        end
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    function automatic addr_t make_addr(input set_idx_t s, input int k, input logic [3:0] off);
        tag_t t;
        t = {4'(k + 1), 8'h00, s};
        return {t, s, off, 2'b00};
    endfunction

    function automatic logic [1:0] plru_victim(input logic [2:0] t);
        if (!t[2]) begin
            return t[1] ? 2'd1 : 2'd0;
        end
        return t[0] ? 2'd3 : 2'd2;
    endfunction

    // touched way is pointed away from at each level
    function automatic logic [2:0] plru_touch(input logic [2:0] t, input logic [1:0] w);
        logic [2:0] n;
        n = t;
        if (w < 2'd2) begin
            n[2] = 1'b1;
            n[1] = (w == 2'd0);
        end else begin
            n[2] = 1'b0;
            n[0] = (w == 2'd2);
        end
        return n;
    endfunction

    task automatic step_cycle();
        int unsigned r;
        @(posedge clk);
        take_bits(4, r);
        ar_stall <= r[0];
        r_stall  <= r[1];
        if (stall_cycles > 0) begin
            instr_ready_i <= 1'b0;
            stall_cycles--;
        end else begin
            instr_ready_i <= |r[3:2];
        end
    endtask

    task automatic fetch(input addr_t a, input int ready_hold);
        set_idx_t   s;
        tag_t       t;
        logic       hit;
        logic [1:0] way;
        logic       done;
        s   = a[12:6];
        t   = a[31:13];
        hit = 1'b0;
        way = 2'd0;
        for (int w = 3; w >= 0; w--) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = plru_victim(model_plru);
            for (int w = 3; w >= 0; w--) begin
                if (!model_valid[s][w]) begin
                    way = 2'(w);
                end
            end
            model_valid[s][way] = !a[20];
            model_tag[s][way]   = t;
        end
        if (hit || !a[20]) begin
            model_plru = plru_touch(model_plru, way);
        end
        step_cycle();
        instr_mem_req_i  <= 1'b1;
        instr_mem_addr_i <= a;
        exp_hit          <= hit;
        exp_exc          <= a[20];
        exp_way          <= way;
        exp_word         <= a ^ 32'h5EED_0000;
        exp_line         <= {a[31:6], 6'h00};
        stall_cycles = ready_hold;
        do begin
            @(negedge clk);
            done = instr_mem_ready_o;
            step_cycle();
        end while (!done);
        instr_mem_req_i <= 1'b0;
        do begin
            @(negedge clk);
            done = delivered;
            step_cycle();
        end while (!done);
    endtask

    a_reset_idle: assert property (@(posedge clk) $rose(resetn) |->
        !arvalid_o && !rready_o && !instr_valid_o && !exc_valid_o && instr_mem_ready_o)
        else begin
            proto_errors++;
            $display("outputs were not idle when reset was released");
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!resetn)
        accepted && exp_hit |=> instr_valid_o)
        else begin
            proto_errors++;
            $display("hit in test %s was not delivered one cycle after acceptance", test_name);
        end

    a_miss_timing: assert property (@(posedge clk) disable iff (!resetn)
        accepted && !exp_hit |=> !instr_mem_ready_o && !instr_valid_o ##1 arvalid_o)
        else begin
            proto_errors++;
            $display("miss in test %s did not start its burst on time", test_name);
        end

    a_burst_fields: assert property (@(posedge clk) disable iff (!resetn)
        arvalid_o |-> araddr_o == exp_line && arlen_o == 8'd3 && arsize_o == 3'd4
            && arburst_o == 2'd1)
        else begin
            data_errors++;
            $display("Mismatch %s: expected burst %08h/3/4/1, actual %08h/%0d/%0d/%0d",
                test_name, $sampled(exp_line), $sampled(araddr_o), $sampled(arlen_o),
                $sampled(arsize_o), $sampled(arburst_o));
        end

    a_burst_count: assert property (@(posedge clk) disable iff (!resetn)
        delivered |-> ar_count == (exp_hit ? 0 : 1))
        else begin
            data_errors++;
            $display("Mismatch %s: expected %0d bursts, actual %0d", test_name,
                $sampled(exp_hit) ? 0 : 1, $sampled(ar_count));
        end

    a_fill_way: assert property (@(posedge clk) disable iff (!resetn)
        uut.fill.we |-> uut.fill.way == exp_way)
        else begin
            data_errors++;
            $display("Mismatch %s: expected fill way %0d, actual %0d", test_name,
                $sampled(exp_way), $sampled(uut.fill.way));
        end

    a_word: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid_o && instr_ready_i |-> instr_o == exp_word)
        else begin
            data_errors++;
            $display("Mismatch %s: expected %08h, actual %08h", test_name,
                $sampled(exp_word), $sampled(instr_o));
        end

    a_exc: assert property (@(posedge clk) disable iff (!resetn)
        exc_valid_o |-> exp_exc && exc_code_o == 5'd1)
        else begin
            data_errors++;
            $display("Mismatch %s: expected exception %0b code 1, actual exception 1 code %0d",
                test_name, $sampled(exp_exc), $sampled(exc_code_o));
        end

    a_no_word_on_error: assert property (@(posedge clk) disable iff (!resetn)
        exp_exc |-> !instr_valid_o)
        else begin
            proto_errors++;
            $display("an instruction was delivered for a faulting fetch in test %s", test_name);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid_o && !instr_ready_i |=> instr_valid_o && $stable(instr_o))
        else begin
            proto_errors++;
            $display("instruction output changed while stalled in test %s", test_name);
        end

    a_stall_block: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid_o && !instr_ready_i |-> !instr_mem_ready_o)
        else begin
            proto_errors++;
            $display("a new fetch was offered while stalled in test %s", test_name);
        end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_FETCHES));
        $display("watchdog expired before all fetches finished");
        $display("errors: data %0d, protocol %0d", data_errors, proto_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        int unsigned r;
        int unsigned k;
        set_idx_t    s;
        set_idx_t    sel;
        addr_t       a;
        addr_t       cold;
        lfsr             = 16'd44;
        resetn           = 1'b0;
        instr_mem_req_i  = 1'b0;
        instr_mem_addr_i = '0;
        instr_ready_i    = 1'b1;
        ar_stall         = 1'b0;
        r_stall          = 1'b0;
        exp_word         = '0;
        exp_line         = '0;
        exp_hit          = 1'b0;
        exp_exc          = 1'b0;
        exp_way          = '0;
        stall_cycles     = 0;
        data_errors      = 0;
        proto_errors     = 0;
        model_plru       = '0;
        test_name        = "reset";
        for (int i = 0; i < 128; i++) begin
            for (int w = 0; w < 4; w++) begin
                model_valid[i][w] = 1'b0;
                model_tag[i][w]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        test_name = "cold_miss";
        take_bits(7, r);
        s = set_idx_t'(r);
        take_bits(4, r);
        cold = make_addr(s, 0, 4'(r));
        fetch(cold, 0);

        // other word of the same line
        test_name = "hit";
        fetch(cold ^ 32'h3C, 0);

        test_name = "replacement";
        take_bits(7, r);
        s = set_idx_t'(r);
        for (int i = 0; i < 5; i++) begin
            take_bits(4, r);
            fetch(make_addr(s, i, 4'(r)), 0);
            take_bits(3, r);
            fetch(make_addr(s, r % 6, 4'(r)), 0);
        end
        for (int i = 0; i < 5; i++) begin
            fetch(make_addr(s, i, 4'hF), 0);
        end

        test_name = "error";
        take_bits(7, r);
        s = set_idx_t'(r);
        a = make_addr(s, 2, 4'h5) | 32'h0010_0000;
        fetch(a, 0);
        fetch(a, 0);

        test_name = "stall";
        fetch(cold, 6);

        test_name = "random";
        take_bits(7, r);
        s = set_idx_t'(r);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(2, r);
            sel = s + set_idx_t'(r);
            take_bits(3, r);
            k = r;
            take_bits(4, r);
            a = make_addr(sel, k % 6, 4'(r));
            // tag picks 6 and 7 land in the faulting region
            if (k >= 6) begin
                a = a | 32'h0010_0000;
            end
            fetch(a, 0);
        end

        test_name = "end";
        repeat (2) step_cycle();
        $display("errors: data %0d, protocol %0d", data_errors, proto_errors);
        if (data_errors + proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icache_proj.f */
common/icache_pkg.sv
icache/icache_plru.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_ctrl.sv
icache/icache_top.sv
test/tb_axi_mem.sv
test/tb_icache.sv

/* Bender.yml */
package:
  name: icache_proj

sources:
  - common/icache_pkg.sv
  - icache/icache_plru.sv
  - icache/icache_tag_array.sv
  - icache/icache_data_array.sv
  - icache/icache_ctrl.sv
  - icache/icache_top.sv
  - target: test
    files:
      - test/tb_axi_mem.sv
      - test/tb_icache.sv
